// ==== src/issue_pkg.sv ====
/* Issue stage package: sizes, instruction layout and push group types
   shared by the issue buffer, the register scoreboard and the top level. */
package issue_pkg;

    // Physical register file seen by the scoreboard.
    localparam int NUM_PREGS = 10;
    localparam int PREG_W    = 4;   // Tag width, covers NUM_PREGS.

    // Front end delivers up to this many instructions per cycle.
    localparam int PUSH_WIDTH = 4;

    // Issue buffer depth.
    localparam int ISSUE_ENTRIES = 4;

    // Push counts run from 0 to PUSH_WIDTH inclusive.
    localparam int COUNT_W = 3;

    typedef logic [PREG_W-1:0] preg_t;

    // One decoded and renamed instruction, 30 bits.
    typedef struct packed {
        logic [7:0] opcode;
        preg_t      dest;    // Written on completion.
        preg_t      src1;
        preg_t      src2;
        logic [9:0] imm;
    } issue_instr_t;

    // Element 0 is the oldest of the group.
    typedef issue_instr_t [PUSH_WIDTH-1:0] push_group_t;

    // A set bit means the register value is available.
    typedef logic [NUM_PREGS-1:0] done_vec_t;

endpackage

// ==== src/first_one_enc.sv ====
/* Lowest-set-bit priority encoder, used to pick the issue slot. */
module first_one_enc #(
    parameter int WIDTH = issue_pkg::ISSUE_ENTRIES
) (
    input  logic [WIDTH-1:0]         req,
    output logic                     any,
    output logic [$clog2(WIDTH)-1:0] index
);

    localparam int IDX_W = $clog2(WIDTH);

    // Scan from the top so the lowest set bit wins.
    always_comb begin
        any   = 1'b0;
        index = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req[i]) begin
                any   = 1'b1;
                index = IDX_W'(i);
            end
        end
    end

endmodule

// ==== src/issue_entry.sv ====
/* Issue buffer slot: holds one instruction until it issues and flags
   it ready once both source registers are done. */
module issue_entry (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  write_en,
    input  issue_pkg::issue_instr_t instr_in,
    input  issue_pkg::done_vec_t  done_flags,
    input  logic                  issue_en,
    output logic                  occupied,
    output logic                  ready,
    output issue_pkg::issue_instr_t instr_out
);

    import issue_pkg::*;

    logic         occupied_q;
    issue_instr_t instr_q;
    logic         src1_done;
    logic         src2_done;

    // Slot state. Write and issue never hit the same slot together.
    always_ff @(posedge clk) begin
        if (rst) begin
            occupied_q <= 1'b0;
        end else if (write_en) begin
            occupied_q <= 1'b1;
        end else if (issue_en) begin
            occupied_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (write_en) begin
            instr_q <= instr_in;
        end
    end

    // Tags past the register file are never done.
    assign src1_done = (int'(instr_q.src1) < NUM_PREGS) && done_flags[instr_q.src1];
    assign src2_done = (int'(instr_q.src2) < NUM_PREGS) && done_flags[instr_q.src2];

    // Re-evaluated every cycle, so a writeback wakes the slot directly.
    assign ready = occupied_q && src1_done && src2_done;

    assign occupied  = occupied_q;
    assign instr_out = instr_q;

endmodule

// ==== src/reg_scoreboard.sv ====
/* Register scoreboard: one done bit per physical register, cleared on
   allocation and set again by the writeback pulse. */
module reg_scoreboard (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [issue_pkg::PUSH_WIDTH-1:0]          alloc_mask,
    input  issue_pkg::preg_t [issue_pkg::PUSH_WIDTH-1:0] alloc_dests,
    input  logic                                      wb_valid,
    input  issue_pkg::preg_t                          wb_tag,
    output issue_pkg::done_vec_t                      done_flags
);

    import issue_pkg::*;

    done_vec_t done_q;
    done_vec_t done_next;

    always_comb begin
        done_next = done_q;

        // Completion first.
        if (wb_valid && (int'(wb_tag) < NUM_PREGS)) begin
            done_next[wb_tag] = 1'b1;
        end

        // A new producer of the same tag overrides the writeback.
        for (int k = 0; k < PUSH_WIDTH; k++) begin
            if (alloc_mask[k] && (int'(alloc_dests[k]) < NUM_PREGS)) begin
                done_next[alloc_dests[k]] = 1'b0;
            end
        end
    end

    // All registers hold architectural values out of reset.
    always_ff @(posedge clk) begin
        if (rst) begin
            done_q <= '1;
        end else begin
            done_q <= done_next;
        end
    end

    assign done_flags = done_q;

endmodule

// ==== src/issue_buffer.sv ====
/* Out-of-order issue buffer: takes a counted push group into free slots
   and issues the lowest ready slot on a valid/ready port. */
module issue_buffer (
    input  logic                                      clk,
    input  logic                                      rst,
    input  issue_pkg::push_group_t                    din,
    input  logic [issue_pkg::COUNT_W-1:0]             din_valid_ct,
    output logic [issue_pkg::COUNT_W-1:0]             din_ready_ct,
    output issue_pkg::issue_instr_t                   dout,
    output logic                                      dout_valid,
    input  logic                                      dout_ready,
    input  issue_pkg::done_vec_t                      done_flags,
    output logic [issue_pkg::PUSH_WIDTH-1:0]          alloc_mask,
    output issue_pkg::preg_t [issue_pkg::PUSH_WIDTH-1:0] alloc_dests
);

    import issue_pkg::*;

    localparam int SEL_W = $clog2(ISSUE_ENTRIES);
    localparam int PIDX_W = $clog2(PUSH_WIDTH);

    logic [ISSUE_ENTRIES-1:0] occupied_mask;
    logic [ISSUE_ENTRIES-1:0] ready_mask;
    logic [ISSUE_ENTRIES-1:0] free_mask;
    logic [ISSUE_ENTRIES-1:0] write_en;
    logic [ISSUE_ENTRIES-1:0] issue_en;

    issue_instr_t [ISSUE_ENTRIES-1:0] entry_in;
    issue_instr_t [ISSUE_ENTRIES-1:0] entry_out;

    logic [COUNT_W-1:0] free_ct;
    logic [COUNT_W-1:0] accept_ct;
    logic [COUNT_W-1:0] push_idx;
    logic [SEL_W-1:0]   sel_idx;

    for (genvar s = 0; s < ISSUE_ENTRIES; s++) begin : g_entry
        issue_entry u_entry (
            .clk        (clk),
            .rst        (rst),
            .write_en   (write_en[s]),
            .instr_in   (entry_in[s]),
            .done_flags (done_flags),
            .issue_en   (issue_en[s]),
            .occupied   (occupied_mask[s]),
            .ready      (ready_mask[s]),
            .instr_out  (entry_out[s])
        );
    end

    assign free_mask = ~occupied_mask;

    // Free slot count, capped at the group size.
    always_comb begin
        free_ct = '0;
        for (int s = 0; s < ISSUE_ENTRIES; s++) begin
            free_ct = free_ct + COUNT_W'(free_mask[s]);
        end
    end

    assign din_ready_ct = (free_ct > COUNT_W'(PUSH_WIDTH)) ? COUNT_W'(PUSH_WIDTH) : free_ct;
    assign accept_ct = (din_valid_ct < din_ready_ct) ? din_valid_ct : din_ready_ct;

    // Accepted elements go to free slots in ascending order.
    always_comb begin
        write_en = '0;
        entry_in = '0;
        push_idx = '0;
        for (int s = 0; s < ISSUE_ENTRIES; s++) begin
            if (free_mask[s] && (push_idx < accept_ct)) begin
                write_en[s] = 1'b1;
                entry_in[s] = din[push_idx[PIDX_W-1:0]];
                push_idx    = push_idx + 1'b1;
            end
        end
    end

    // Only leading elements are ever taken.
    always_comb begin
        for (int k = 0; k < PUSH_WIDTH; k++) begin
            alloc_mask[k]  = (k < int'(accept_ct));
            alloc_dests[k] = din[k].dest;
        end
    end

    first_one_enc #(
        .WIDTH (ISSUE_ENTRIES)
    ) u_sel (
        .req   (ready_mask),
        .any   (dout_valid),
        .index (sel_idx)
    );

    assign dout = entry_out[sel_idx];

    // Slot frees on the transfer edge.
    always_comb begin
        issue_en = '0;
        if (dout_valid && dout_ready) begin
            issue_en[sel_idx] = 1'b1;
        end
    end

endmodule

// ==== src/issue_unit_top.sv ====
/* Issue unit top: the issue buffer fed by the register scoreboard. */
module issue_unit_top (
    input  logic                          clk,
    input  logic                          rst,
    input  issue_pkg::push_group_t        din,
    input  logic [issue_pkg::COUNT_W-1:0] din_valid_ct,
    output logic [issue_pkg::COUNT_W-1:0] din_ready_ct,
    output issue_pkg::issue_instr_t       dout,
    output logic                          dout_valid,
    input  logic                          dout_ready,
    input  logic                          wb_valid,
    input  issue_pkg::preg_t              wb_tag
);

    import issue_pkg::*;

    logic [PUSH_WIDTH-1:0]  alloc_mask;
    preg_t [PUSH_WIDTH-1:0] alloc_dests;
    done_vec_t              done_flags;

    issue_buffer u_buffer (
        .clk          (clk),
        .rst          (rst),
        .din          (din),
        .din_valid_ct (din_valid_ct),
        .din_ready_ct (din_ready_ct),
        .dout         (dout),
        .dout_valid   (dout_valid),
        .dout_ready   (dout_ready),
        .done_flags   (done_flags),
        .alloc_mask   (alloc_mask),
        .alloc_dests  (alloc_dests)
    );

    reg_scoreboard u_scoreboard (
        .clk         (clk),
        .rst         (rst),
        .alloc_mask  (alloc_mask),
        .alloc_dests (alloc_dests),
        .wb_valid    (wb_valid),
        .wb_tag      (wb_tag),
        .done_flags  (done_flags)   // Registered, one edge behind alloc.
    );

endmodule

// ==== testbench/issue_unit_sva.sv ====
/* Protocol assertions bound into the issue unit top level. */
module issue_unit_sva (
    input logic                                      clk,
    input logic                                      rst,
    input logic [issue_pkg::COUNT_W-1:0]             din_ready_ct,
    input issue_pkg::issue_instr_t                   dout,
    input logic                                      dout_valid,
    input logic                                      dout_ready,
    input logic [$clog2(issue_pkg::ISSUE_ENTRIES)-1:0] sel_idx
);

    import issue_pkg::*;

    int assert_fails = 0;

    // A held output may only move to a lower slot that just woke.
    property hold_under_backpressure;
        @(posedge clk) disable iff (rst)
        (dout_valid && !dout_ready) |=>
            dout_valid && ($stable(dout) || (sel_idx < $past(sel_idx)));
    endproperty

    // Free count only grows by the slot that just issued.
    property ready_count_in_range;
        @(posedge clk) disable iff (rst)
        (din_ready_ct <= COUNT_W'(PUSH_WIDTH)) &&
            (din_ready_ct <= $past(din_ready_ct) + COUNT_W'($past(dout_valid && dout_ready)));
    endproperty

    property idle_after_reset;
        @(posedge clk) $fell(rst) |-> !dout_valid;
    endproperty

    a_hold: assert property (hold_under_backpressure) else begin
        $error("dout changed while stalled by dout_ready");
        assert_fails++;
    end

    a_count: assert property (ready_count_in_range) else begin
        $error("din_ready_ct above the push width or grown without an issue");
        assert_fails++;
    end

    a_reset: assert property (idle_after_reset) else begin
        $error("dout_valid high in the first cycle after reset");
        assert_fails++;
    end

endmodule

bind issue_unit_top issue_unit_sva u_sva (
    .clk          (clk),
    .rst          (rst),
    .din_ready_ct (din_ready_ct),
    .dout         (dout),
    .dout_valid   (dout_valid),
    .dout_ready   (dout_ready),
    .sel_idx      (u_buffer.sel_idx)
);

// ==== testbench/issue_unit_tb.sv ====
/* Testbench for the issue unit. Directed tests and a random mix are
   checked every cycle against a slot and scoreboard model. */
module issue_unit_tb;

    import issue_pkg::*;

    localparam int RANDOM_CYCLES = 400;
    // Directed tests and drains need under 200 cycles and the random mix about 450.
    localparam int CYCLE_LIMIT = 2000;

    logic               clk;
    logic               rst;
    push_group_t        din;
    logic [COUNT_W-1:0] din_valid_ct;
    logic [COUNT_W-1:0] din_ready_ct;
    issue_instr_t       dout;
    logic               dout_valid;
    logic               dout_ready;
    logic               wb_valid;
    preg_t              wb_tag;

    logic         m_occ [ISSUE_ENTRIES];   // Model slots.
    issue_instr_t m_instr [ISSUE_ENTRIES];
    done_vec_t    m_done;
    issue_instr_t issued_q [$];

    int seed = 84731;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int tests = 0;
    int errors_at_start = 0;

    issue_unit_top UUT (
        .clk          (clk),
        .rst          (rst),
        .din          (din),
        .din_valid_ct (din_valid_ct),
        .din_ready_ct (din_ready_ct),
        .dout         (dout),
        .dout_valid   (dout_valid),
        .dout_ready   (dout_ready),
        .wb_valid     (wb_valid),
        .wb_tag       (wb_tag)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check_instr(string what, issue_instr_t got, issue_instr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_count(string what, logic [COUNT_W-1:0] got, logic [COUNT_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(string what, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic issue_instr_t build_instr(logic [7:0] op, preg_t dest, preg_t s1,
                                                 preg_t s2, logic [9:0] imm);
        issue_instr_t i;
        i.opcode = op;
        i.dest   = dest;
        i.src1   = s1;
        i.src2   = s2;
        i.imm    = imm;
        return i;
    endfunction

    // Lowest occupied slot with both sources done, else -1.
    function automatic int model_sel();
        for (int s = 0; s < ISSUE_ENTRIES; s++) begin
            if (m_occ[s] && m_done[m_instr[s].src1] && m_done[m_instr[s].src2]) begin
                return s;
            end
        end
        return -1;
    endfunction

    function automatic int model_occupied();
        int n = 0;
        for (int s = 0; s < ISSUE_ENTRIES; s++) begin
            if (m_occ[s]) n++;
        end
        return n;
    endfunction

    function automatic int model_free_ct();
        int n = ISSUE_ENTRIES - model_occupied();
        return (n > PUSH_WIDTH) ? PUSH_WIDTH : n;
    endfunction

    // Random pick among the set bits or -1 when none is set.
    function automatic int pick_tag(done_vec_t avail);
        int cand [$];
        for (int t = 0; t < NUM_PREGS; t++) begin
            if (avail[t]) cand.push_back(t);
        end
        if (cand.size() == 0) return -1;
        return cand[$unsigned($random(seed)) % cand.size()];
    endfunction

    // Applies one rising edge to the model from pre-edge state.
    task automatic update_model();
        logic      occ_pre [ISSUE_ENTRIES];
        done_vec_t done_nx;
        int        sel;
        int        accept;
        int        k;
        sel = model_sel();
        accept = model_free_ct();
        if (int'(din_valid_ct) < accept) accept = int'(din_valid_ct);
        occ_pre = m_occ;
        done_nx = m_done;
        if (wb_valid) done_nx[wb_tag] = 1'b1;
        for (k = 0; k < accept; k++) begin
            done_nx[din[k].dest] = 1'b0;   // Allocation beats writeback.
        end
        if (sel >= 0 && dout_ready) begin
            m_occ[sel] = 1'b0;
        end
        k = 0;
        for (int s = 0; s < ISSUE_ENTRIES; s++) begin
            if (!occ_pre[s] && k < accept) begin
                m_occ[s]   = 1'b1;
                m_instr[s] = din[k];
                k++;
            end
        end
        m_done = done_nx;
    endtask

    task automatic compare_outputs();
        int sel;
        sel = model_sel();
        check_flag("dout_valid", dout_valid, sel >= 0);
        if (sel >= 0) check_instr("dout", dout, m_instr[sel]);
        check_count("din_ready_ct", din_ready_ct, COUNT_W'(model_free_ct()));
    endtask

    // Logs a DUT transfer, advances the model at the rising edge and compares at the fall.
    task automatic step();
        if (dout_valid && dout_ready) begin
            issued_q.push_back(dout);
        end
        @(posedge clk);
        update_model();
        @(negedge clk);
        compare_outputs();
        din_valid_ct = '0;
        wb_valid     = 1'b0;
    endtask

    task automatic release_all();
        dout_ready = 1'b1;
        for (int t = 0; t < NUM_PREGS; t++) begin
            if (!m_done[t]) begin
                wb_valid = 1'b1;
                wb_tag   = preg_t'(t);
                step();
            end
        end
        while (model_occupied() > 0 || dout_valid) step();
    endtask

    task automatic end_test(string name);
        tests++;
        $display("Test %-18s finished, %0d errors", name, errors - errors_at_start);
        errors_at_start = errors;
    endtask

    task automatic test_reset();
        compare_outputs();
        check_flag("dout_valid after reset", dout_valid, 1'b0);
        check_count("din_ready_ct after reset", din_ready_ct, COUNT_W'(PUSH_WIDTH));
        end_test("reset");
    endtask

    task automatic test_pass_through();
        push_group_t grp;
        for (int k = 0; k < PUSH_WIDTH; k++) begin
            grp[k] = build_instr(8'h10 + 8'(k), preg_t'(k), preg_t'(8), preg_t'(9), 10'(k * 37));
        end
        dout_ready   = 1'b1;
        din          = grp;
        din_valid_ct = COUNT_W'(PUSH_WIDTH);
        step();
        for (int k = 0; k < PUSH_WIDTH; k++) begin
            check_flag("dout_valid in order", dout_valid, 1'b1);
            check_instr("dout in order", dout, grp[k]);
            step();
        end
        check_flag("dout_valid when empty", dout_valid, 1'b0);
        release_all();
        end_test("pass_through");
    endtask

    task automatic test_dependency_wakeup();
        issue_instr_t prod;
        issue_instr_t cons;
        prod = build_instr(8'h21, preg_t'(4), preg_t'(8), preg_t'(9), 10'h0a1);
        cons = build_instr(8'h22, preg_t'(5), preg_t'(4), preg_t'(9), 10'h0a2);
        dout_ready   = 1'b1;
        din[0]       = prod;
        din[1]       = cons;
        din_valid_ct = COUNT_W'(2);
        step();
        check_instr("producer", dout, prod);
        step();
        repeat (3) begin
            check_flag("consumer waiting", dout_valid, 1'b0);
            step();
        end
        wb_valid = 1'b1;
        wb_tag   = preg_t'(4);
        step();
        check_flag("consumer woken", dout_valid, 1'b1);
        check_instr("consumer", dout, cons);
        step();
        check_flag("dout_valid after consumer", dout_valid, 1'b0);
        release_all();
        end_test("dependency_wakeup");
    endtask

    task automatic test_out_of_order();
        issue_instr_t prod;
        issue_instr_t older;
        issue_instr_t younger;
        prod    = build_instr(8'h31, preg_t'(5), preg_t'(8), preg_t'(9), 10'h111);
        older   = build_instr(8'h32, preg_t'(6), preg_t'(5), preg_t'(9), 10'h222);
        younger = build_instr(8'h33, preg_t'(7), preg_t'(8), preg_t'(9), 10'h333);
        dout_ready   = 1'b1;
        din[0]       = prod;
        din[1]       = older;
        din[2]       = younger;
        din_valid_ct = COUNT_W'(3);
        step();
        check_instr("producer", dout, prod);
        step();
        check_instr("younger passes older", dout, younger);
        step();
        check_flag("older still waiting", dout_valid, 1'b0);
        wb_valid = 1'b1;
        wb_tag   = preg_t'(5);
        step();
        check_instr("older after wakeup", dout, older);
        step();
        release_all();
        end_test("out_of_order");
    endtask

    task automatic test_full_backpressure();
        push_group_t  grp;
        push_group_t  late;
        issue_instr_t exp_order [6];
        int           base;
        for (int k = 0; k < PUSH_WIDTH; k++) begin
            grp[k]  = build_instr(8'h40 + 8'(k), preg_t'(k), preg_t'(8), preg_t'(9), 10'(k));
            late[k] = build_instr(8'h50 + 8'(k), preg_t'(k + 4), preg_t'(8), preg_t'(9), 10'(k));
        end
        base         = issued_q.size();
        dout_ready   = 1'b0;
        din          = grp;
        din_valid_ct = COUNT_W'(PUSH_WIDTH);
        step();
        check_count("din_ready_ct when full", din_ready_ct, '0);
        din = late;
        repeat (3) begin
            din_valid_ct = COUNT_W'(2);   // Refused while full.
            step();
            check_count("din_ready_ct still full", din_ready_ct, '0);
            check_instr("held dout", dout, grp[0]);
        end
        dout_ready = 1'b1;
        step();
        step();
        dout_ready = 1'b0;
        check_count("din_ready_ct after two issues", din_ready_ct, COUNT_W'(2));
        din_valid_ct = COUNT_W'(3);
        step();
        check_count("din_ready_ct after partial push", din_ready_ct, '0);
        release_all();
        exp_order = '{grp[0], grp[1], late[0], late[1], grp[2], grp[3]};
        check_count("issued count", COUNT_W'(issued_q.size() - base), COUNT_W'(6));
        for (int i = 0; i < $size(exp_order) && base + i < issued_q.size(); i++) begin
            check_instr("issue order", issued_q[base + i], exp_order[i]);
        end
        end_test("full_backpressure");
    endtask

    task automatic test_random_mix();
        done_vec_t used;
        done_vec_t wb_avail;
        int        cnt;
        int        tag;
        preg_t     s1;
        preg_t     s2;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            dout_ready = ($random(seed) & 3) != 0;
            cnt = $unsigned($random(seed)) % (PUSH_WIDTH + 1);
            // Busy tags and tags still read or written in the buffer are off limits.
            used     = ~m_done;
            wb_avail = ~m_done;
            for (int s = 0; s < ISSUE_ENTRIES; s++) begin
                if (m_occ[s]) begin
                    used[m_instr[s].src1]    = 1'b1;
                    used[m_instr[s].src2]    = 1'b1;
                    used[m_instr[s].dest]    = 1'b1;
                    wb_avail[m_instr[s].dest] = 1'b0;
                end
            end
            for (int k = 0; k < cnt; k++) begin
                s1 = preg_t'($unsigned($random(seed)) % NUM_PREGS);
                s2 = preg_t'($unsigned($random(seed)) % NUM_PREGS);
                used[s1] = 1'b1;
                used[s2] = 1'b1;
                tag = pick_tag(~used);
                if (tag < 0) begin
                    cnt = k;
                    break;
                end
                used[tag] = 1'b1;
                din[k] = build_instr(8'($random(seed)), preg_t'(tag), s1, s2,
                                     10'($random(seed)));
            end
            din_valid_ct = COUNT_W'(cnt);
            tag = pick_tag(wb_avail);   // Producer already left the buffer.
            if (($random(seed) & 1) && tag >= 0) begin
                wb_valid = 1'b1;
                wb_tag   = preg_t'(tag);
            end
            step();
        end
        release_all();
        end_test("random_mix");
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        din          = '0;
        din_valid_ct = '0;
        dout_ready   = 1'b0;
        wb_valid     = 1'b0;
        wb_tag       = '0;
        for (int s = 0; s < ISSUE_ENTRIES; s++) begin
            m_occ[s]   = 1'b0;
            m_instr[s] = '0;
        end
        m_done = '1;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_reset();
        test_pass_through();
        test_dependency_wakeup();
        test_out_of_order();
        test_full_backpressure();
        test_random_mix();

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, UUT.u_sva.assert_fails);
        if (errors == 0 && UUT.u_sva.assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
src/issue_pkg.sv
src/first_one_enc.sv
src/issue_entry.sv
src/reg_scoreboard.sv
src/issue_buffer.sv
src/issue_unit_top.sv
testbench/issue_unit_sva.sv
testbench/issue_unit_tb.sv

// ==== Bender.yml ====
package:
  name: issue_unit

sources:
  # Package first, then leaf modules up to the top level.
  - src/issue_pkg.sv
  - src/first_one_enc.sv
  - src/issue_entry.sv
  - src/reg_scoreboard.sv
  - src/issue_buffer.sv
  - src/issue_unit_top.sv

  - target: test
    files:
      - testbench/issue_unit_sva.sv
      - testbench/issue_unit_tb.sv
